// File: design/snn_pkg.sv
/*
 * Shared definitions for the spiking network processor.
 * Network sizes, firing threshold, leak and connection masks.
 * Command and result packet formats with their opcode enums.
 * Source FSM state encoding.
 */
`default_nettype none

package snn_pkg;

    // ------------------------------------------------------------------------
    // network sizes and neuron constants
    // ------------------------------------------------------------------------
    localparam int num_inp      = 4;
    localparam int num_out      = 4;
    localparam int charge_width = 8;
    localparam int pot_width    = 12;
    localparam int step_width   = 8;
    localparam int queue_depth  = 4;
    localparam int idx_width    = $clog2(num_inp);
    localparam int queue_aw     = $clog2(queue_depth);

    localparam int threshold = 64;   // fires at or above this.
    localparam int leak      = 2;    // per step, positive potentials only.

    // most negative potential, used as the saturation floor.
    localparam logic signed [pot_width-1:0] pot_min = {1'b1, {(pot_width-1){1'b0}}};

    // one mask word per neuron, bit i selects input i.
    localparam logic [num_out-1:0][num_inp-1:0] conn_mask = {
        4'b1111,    // neuron 3, all inputs.
        4'b1100,    // neuron 2, inputs 2 and 3.
        4'b0011,    // neuron 1, inputs 0 and 1.
        4'b0001     // neuron 0, input 0.
    };

    typedef logic signed [charge_width-1:0] charge_t;
    typedef charge_t charge_arr_t [num_inp];

    // ------------------------------------------------------------------------
    // packet formats
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_charge = 3'd1,
        op_run    = 3'd2,
        op_sync   = 3'd3,
        op_clear  = 3'd4
    } src_op_e;

    typedef struct packed {
        src_op_e                 op;
        logic [idx_width-1:0]    index;
        logic [charge_width-1:0] value;   // charge, or step count for op_run.
        logic [2:0]              pad;
    } src_pkt_t;

    typedef enum logic {
        kind_spikes   = 1'b0,
        kind_sync_ack = 1'b1
    } snk_kind_e;

    typedef struct packed {
        snk_kind_e             kind;
        logic [num_out-1:0]    spikes;
        logic [step_width-1:0] step;
        logic [2:0]            pad;
    } snk_pkt_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,
        st_sync = 2'd2
    } src_state_e;

endpackage

`default_nettype wire

// File: design/neuron.sv
/*
 * Integrate-and-fire neuron.
 * Masked charge sum, threshold with reset on fire,
 * leak floored at zero, saturation at the negative bound.
 */
`timescale 1ns/1ns
`default_nettype none

module neuron (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        step,
    input  logic                        clear,
    input  snn_pkg::charge_arr_t        inp,
    input  logic [snn_pkg::num_inp-1:0] mask,
    output logic                        fire
);

    logic signed [snn_pkg::pot_width-1:0] pot;
    logic signed [snn_pkg::pot_width:0]   sum;        // one guard bit.
    logic signed [snn_pkg::pot_width:0]   pot_nxt;

    always_comb begin
        sum = '0;
        for (int i = 0; i < snn_pkg::num_inp; i++) begin
            if (mask[i]) begin
                sum = sum + inp[i];   // sign extended.
            end
        end
        pot_nxt = pot + sum;
        fire    = step && (pot_nxt >= snn_pkg::threshold);
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pot <= '0;
        end else if (step) begin
            if (fire) begin
                pot <= '0;
            end else if (pot_nxt > snn_pkg::leak) begin
                pot <= snn_pkg::pot_width'(pot_nxt - snn_pkg::leak);
            end else if (pot_nxt > 0) begin
                pot <= '0;   // leak floors at zero.
            end else if (pot_nxt < snn_pkg::pot_min) begin
                pot <= snn_pkg::pot_min;
            end else begin
                pot <= snn_pkg::pot_width'(pot_nxt);   // negative, no leak.
            end
        end
    end

endmodule

`default_nettype wire

// File: design/network.sv
/*
 * Single layer of integrate-and-fire neurons.
 * Fixed connection masks from the package, step enable,
 * clear handling, registered spike mask and result strobe.
 */
`timescale 1ns/1ns
`default_nettype none

module network (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        step,
    input  logic                        clear,
    input  snn_pkg::charge_arr_t        inp,
    output logic [snn_pkg::num_out-1:0] out_spikes,
    output logic                        out_valid
);

    logic [snn_pkg::num_out-1:0] fire;
    logic                        step_en;

    // clear takes priority over a step in the same cycle.
    assign step_en = step && !clear;

    // ------------------------------------------------------------------------
    // neuron array
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < snn_pkg::num_out; i++) begin : g_neuron
        neuron u_neuron (
            .clk   (clk),
            .reset (reset),
            .step  (step_en),
            .clear (clear),
            .inp   (inp),
            .mask  (snn_pkg::conn_mask[i]),
            .fire  (fire[i])
        );
    end

    // ------------------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= step_en;   // one cycle after the step.
        end
    end

    always_ff @(posedge clk) begin
        out_spikes <= fire;   // zero outside step cycles.
    end

endmodule

`default_nettype wire

// File: design/network_source.sv
/*
 * Command decoder for the host source stream.
 * Holds pending input charges, counts down runs, and
 * issues step, sync and clear control to the network.
 */
`timescale 1ns/1ns
`default_nettype none

module network_source (
    input  logic                clk,
    input  logic                reset,
    input  snn_pkg::src_pkt_t   src_data,
    input  logic                src_valid,
    input  logic                net_ready,
    output logic                src_ready,
    output snn_pkg::charge_arr_t net_inp,
    output logic                net_step,
    output logic                net_clear,
    output logic                sync_req
);

    snn_pkg::src_state_e           state, state_nxt;
    logic [snn_pkg::step_width-1:0] count;       // steps still to issue.
    logic                          accept;

    assign accept = src_valid && src_ready;

    // ------------------------------------------------------------------------
    // next state and step / sync strobes
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        net_step  = (state == snn_pkg::st_run) && net_ready;
        sync_req  = (state == snn_pkg::st_sync) && net_ready;
        unique case (state)
            snn_pkg::st_idle: begin
                if (accept) begin
                    if (src_data.op == snn_pkg::op_run && src_data.value != '0) begin
                        state_nxt = snn_pkg::st_run;
                    end else if (src_data.op == snn_pkg::op_sync) begin
                        state_nxt = snn_pkg::st_sync;
                    end
                end
            end
            snn_pkg::st_run: begin
                if (net_ready && count == 1) begin
                    state_nxt = snn_pkg::st_idle;   // last step goes out now.
                end
            end
            snn_pkg::st_sync: begin
                if (net_ready) begin
                    state_nxt = snn_pkg::st_idle;
                end
            end
            default: state_nxt = snn_pkg::st_idle;
        endcase
    end

    // ------------------------------------------------------------------------
    // state, counters and pending charges
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= snn_pkg::st_idle;
            count     <= '0;
            src_ready <= 1'b0;
            net_clear <= 1'b0;
            for (int i = 0; i < snn_pkg::num_inp; i++) begin
                net_inp[i] <= '0;
            end
        end else begin
            state     <= state_nxt;
            src_ready <= (state_nxt == snn_pkg::st_idle);
            net_clear <= accept && (src_data.op == snn_pkg::op_clear);
            // charges are used by one step only.
            if (net_step || net_clear) begin
                for (int i = 0; i < snn_pkg::num_inp; i++) begin
                    net_inp[i] <= '0;
                end
            end
            if (accept && src_data.op == snn_pkg::op_charge) begin
                net_inp[src_data.index] <= $signed(src_data.value);   // new charge wins.
            end
            if (accept && src_data.op == snn_pkg::op_run) begin
                count <= snn_pkg::step_width'(src_data.value);
            end else if (net_step) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/network_sink.sv
/*
 * Result packer for the host sink stream.
 * Step counter, small in-order result queue,
 * spike and sync acknowledge packets, back-pressure to the source.
 */
`timescale 1ns/1ns
`default_nettype none

module network_sink (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [snn_pkg::num_out-1:0] out_spikes,
    input  logic                        out_valid,
    input  logic                        sync_req,
    input  logic                        net_clear,
    input  logic                        snk_ready,
    output logic                        net_ready,
    output snn_pkg::snk_pkt_t           snk_data,
    output logic                        snk_valid
);

    snn_pkg::snk_pkt_t              queue [snn_pkg::queue_depth];
    logic [snn_pkg::queue_aw-1:0]   wr_ptr, rd_ptr;
    logic [snn_pkg::queue_aw:0]     used;
    logic [snn_pkg::step_width-1:0] step_cnt, step_nxt;
    snn_pkg::snk_pkt_t              push_pkt;
    logic                           push, pop;

    // ------------------------------------------------------------------------
    // packet assembly
    // ------------------------------------------------------------------------
    // the source keeps sync requests apart from result strobes.
    always_comb begin
        step_nxt = step_cnt + 1'b1;
        push     = 1'b0;
        push_pkt = '0;
        if (out_valid && out_spikes != '0) begin
            push            = 1'b1;
            push_pkt.kind   = snn_pkg::kind_spikes;
            push_pkt.spikes = out_spikes;
            push_pkt.step   = step_nxt;   // stamp after the increment.
        end else if (sync_req) begin
            push          = 1'b1;
            push_pkt.kind = snn_pkg::kind_sync_ack;
            push_pkt.step = step_cnt;
        end
    end

    assign pop       = snk_valid && snk_ready;
    assign snk_valid = (used != '0);
    assign snk_data  = queue[rd_ptr];
    assign net_ready = (used <= snn_pkg::queue_depth - 2);   // room for one in flight.

    // ------------------------------------------------------------------------
    // step counter and queue control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || net_clear) begin
            step_cnt <= '0;
        end else if (out_valid) begin
            step_cnt <= step_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) queue[wr_ptr] <= push_pkt;
    end

endmodule

`default_nettype wire

// File: design/snn_processor.sv
/*
 * Top level of the spiking network processor.
 * Command source, neuron layer and result sink on two streams.
 */
`timescale 1ns/1ns
`default_nettype none

module snn_processor (
    input  logic              clk,
    input  logic              reset,
    input  snn_pkg::src_pkt_t src_data,
    input  logic              src_valid,
    output logic              src_ready,
    output snn_pkg::snk_pkt_t snk_data,
    output logic              snk_valid,
    input  logic              snk_ready
);

    snn_pkg::charge_arr_t        net_inp;
    logic                        net_step, net_clear, net_ready, sync_req;
    logic [snn_pkg::num_out-1:0] out_spikes;
    logic                        out_valid;

    network_source u_source (
        .clk       (clk),
        .reset     (reset),
        .src_data  (src_data),
        .src_valid (src_valid),
        .net_ready (net_ready),
        .src_ready (src_ready),
        .net_inp   (net_inp),
        .net_step  (net_step),
        .net_clear (net_clear),
        .sync_req  (sync_req)
    );

    network u_network (
        .clk        (clk),
        .reset      (reset),
        .step       (net_step),
        .clear      (net_clear),
        .inp        (net_inp),
        .out_spikes (out_spikes),
        .out_valid  (out_valid)
    );

    network_sink u_sink (
        .clk        (clk),
        .reset      (reset),
        .out_spikes (out_spikes),
        .out_valid  (out_valid),
        .sync_req   (sync_req),
        .net_clear  (net_clear),
        .snk_ready  (snk_ready),
        .net_ready  (net_ready),
        .snk_data   (snk_data),
        .snk_valid  (snk_valid)
    );

endmodule

`default_nettype wire

// File: test/snn_processor_props.sv
/*
 * Concurrent assertions for the processor streams.
 * Stall stability on the result stream, source held off
 * while a run issues steps, result stream idle after reset.
 */
`timescale 1ns/1ns
`default_nettype none

module snn_processor_props (
    input logic              clk,
    input logic              reset,
    input logic              src_ready,
    input snn_pkg::snk_pkt_t snk_data,
    input logic              snk_valid,
    input logic              snk_ready,
    input logic              net_step
);

    // a stalled result stays on the bus unchanged.
    snk_hold: assert property (@(posedge clk) disable iff (reset)
        snk_valid && !snk_ready |=> snk_valid && $stable(snk_data))
        else $error("snk_valid or snk_data changed while stalled");

    // no new command while steps go out.
    run_gate: assert property (@(posedge clk) disable iff (reset)
        net_step |-> !src_ready)
        else $error("src_ready high during a run");

    reset_idle: assert property (@(posedge clk)
        reset |=> !snk_valid)
        else $error("snk_valid high in the cycle after reset");

endmodule

bind snn_processor snn_processor_props u_props (
    .clk       (clk),
    .reset     (reset),
    .src_ready (src_ready),
    .snk_data  (snk_data),
    .snk_valid (snk_valid),
    .snk_ready (snk_ready),
    .net_step  (net_step)
);

`default_nettype wire

// File: test/snn_processor_tb.sv
/*
 * Testbench for the spiking network processor.
 * Command table with sink stall modes, a reference model of
 * the neuron layer and sink queue, packet compare tasks,
 * cycle limit and final report.
 */
`timescale 1ns/1ns
`default_nettype none

module snn_processor_tb;

    typedef struct packed {
        snn_pkg::src_pkt_t cmd;
        logic              stall;   // random snk_ready while set.
    } entry_t;

    logic              clk;
    logic              reset;
    snn_pkg::src_pkt_t src_data;
    logic              src_valid;
    logic              src_ready;
    snn_pkg::snk_pkt_t snk_data;
    logic              snk_valid;
    logic              snk_ready;

    entry_t            stim [$];
    snn_pkg::snk_pkt_t exp_q [$];
    logic              stall_mode;
    int                cycles;
    int                limit;

    snn_processor uut (
        .clk       (clk),
        .reset     (reset),
        .src_data  (src_data),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .snk_data  (snk_data),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic report_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_pkt(input string name, input snn_pkg::snk_pkt_t got,
                             input snn_pkg::snk_pkt_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic add_cmd(input snn_pkg::src_op_e op, input int index,
                           input int value, input logic stall);
        entry_t e;
        e           = '0;
        e.cmd.op    = op;
        e.cmd.index = 2'(index);
        e.cmd.value = 8'(value);
        e.stall     = stall;
        stim.push_back(e);
    endtask

    task automatic fill_table();
        add_cmd(snn_pkg::op_charge, 0, 40, 1'b0);     // neurons 1 to 3 fire.
        add_cmd(snn_pkg::op_charge, 1, 30, 1'b0);
        add_cmd(snn_pkg::op_charge, 2, 70, 1'b0);
        add_cmd(snn_pkg::op_run,    0, 1,  1'b0);
        add_cmd(snn_pkg::op_charge, 0, 10, 1'b0);     // sub-threshold, leaks away.
        add_cmd(snn_pkg::op_run,    0, 3,  1'b0);
        add_cmd(snn_pkg::op_charge, 0, 30, 1'b0);
        add_cmd(snn_pkg::op_run,    0, 1,  1'b0);
        add_cmd(snn_pkg::op_charge, 3, 100, 1'b1);    // stalled sink from here.
        add_cmd(snn_pkg::op_run,    0, 1,  1'b1);
        add_cmd(snn_pkg::op_charge, 1, 60, 1'b1);
        add_cmd(snn_pkg::op_run,    0, 1,  1'b1);
        add_cmd(snn_pkg::op_charge, 0, 64, 1'b1);
        add_cmd(snn_pkg::op_run,    0, 1,  1'b1);
        add_cmd(snn_pkg::op_charge, 2, -20, 1'b1);
        add_cmd(snn_pkg::op_charge, 3, 90, 1'b1);
        add_cmd(snn_pkg::op_run,    0, 10, 1'b1);
        add_cmd(snn_pkg::op_sync,   0, 0,  1'b1);
        add_cmd(snn_pkg::op_charge, 0, 50, 1'b0);     // potential left behind.
        add_cmd(snn_pkg::op_run,    0, 1,  1'b0);
        add_cmd(snn_pkg::op_charge, 1, 100, 1'b0);    // dropped by the clear.
        add_cmd(snn_pkg::op_clear,  0, 0,  1'b0);
        add_cmd(snn_pkg::op_charge, 0, 20, 1'b0);
        add_cmd(snn_pkg::op_charge, 2, 80, 1'b0);
        add_cmd(snn_pkg::op_run,    0, 1,  1'b0);
        add_cmd(snn_pkg::op_nop,    0, 0,  1'b0);
        add_cmd(snn_pkg::op_run,    0, 0,  1'b1);
        add_cmd(snn_pkg::op_sync,   0, 0,  1'b1);
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    task automatic build_expected();
        int                pot [4];
        int                pend [4];
        int                step_cnt;
        int                run_total;
        int                sum;
        int                nxt;
        logic [3:0]        mask [4];
        logic [3:0]        spikes;
        snn_pkg::snk_pkt_t pkt;
        mask[0]   = 4'b0001;
        mask[1]   = 4'b0011;
        mask[2]   = 4'b1100;
        mask[3]   = 4'b1111;
        step_cnt  = 0;
        run_total = 0;
        for (int n = 0; n < 4; n++) begin
            pot[n]  = 0;
            pend[n] = 0;
        end
        foreach (stim[k]) begin
            case (stim[k].cmd.op)
                snn_pkg::op_charge: pend[stim[k].cmd.index] = $signed(stim[k].cmd.value);
                snn_pkg::op_run: begin
                    run_total = run_total + stim[k].cmd.value;
                    for (int s = 0; s < stim[k].cmd.value; s++) begin
                        step_cnt = (step_cnt + 1) % 256;
                        spikes   = '0;
                        for (int n = 0; n < 4; n++) begin
                            sum = 0;
                            for (int i = 0; i < 4; i++) begin
                                if (mask[n][i]) sum = sum + pend[i];
                            end
                            nxt = pot[n] + sum;
                            if (nxt >= snn_pkg::threshold) begin
                                spikes[n] = 1'b1;
                                pot[n]    = 0;
                            end else if (nxt > 0) begin
                                pot[n] = (nxt > snn_pkg::leak) ? nxt - snn_pkg::leak : 0;
                            end else begin
                                pot[n] = nxt;
                            end
                        end
                        for (int i = 0; i < 4; i++) pend[i] = 0;   // one step only.
                        if (spikes != '0) begin
                            pkt        = '0;
                            pkt.kind   = snn_pkg::kind_spikes;
                            pkt.spikes = spikes;
                            pkt.step   = 8'(step_cnt);
                            exp_q.push_back(pkt);
                        end
                    end
                end
                snn_pkg::op_sync: begin
                    pkt      = '0;
                    pkt.kind = snn_pkg::kind_sync_ack;
                    pkt.step = 8'(step_cnt);
                    exp_q.push_back(pkt);
                end
                snn_pkg::op_clear: begin
                    step_cnt = 0;
                    for (int n = 0; n < 4; n++) begin
                        pot[n]  = 0;
                        pend[n] = 0;
                    end
                end
                default: ;
            endcase
        end
        limit = (run_total + stim.size()) * 8;   // stall factor of 8.
    endtask

    // called at a rising edge, returns at the edge of acceptance.
    task automatic apply_command(input entry_t e);
        stall_mode = e.stall;
        #10;
        src_data  = e.cmd;
        src_valid = 1'b1;
        @(negedge clk);
        while (!src_ready) @(negedge clk);
        @(posedge clk);
    endtask

    // ------------------------------------------------------------------------
    // sink side, timeout and main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(60236));
        snk_ready = 1'b1;
        forever begin
            @(posedge clk);
            #10;
            if (stall_mode) begin
                snk_ready = ($urandom % 3) != 0;
            end else begin
                snk_ready = 1'b1;
            end
        end
    end

    // a transfer seen here completes on the next rising edge.
    always @(negedge clk) begin
        if (!reset && snk_valid && snk_ready) begin
            if (exp_q.size() == 0) begin
                $display("result packet 0x%h arrived with none expected", snk_data);
                report_failure();
            end else begin
                check_pkt("snk_data", snk_data, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, commands or results still outstanding",
                     cycles);
            report_failure();
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        src_valid  = 1'b0;
        src_data   = '0;
        stall_mode = 1'b0;
        cycles     = 0;
        fill_table();
        build_expected();
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_bit("src_ready", src_ready, 1'b0);   // still the reset value.
        check_bit("snk_valid", snk_valid, 1'b0);
        @(posedge clk);
        foreach (stim[k]) begin
            apply_command(stim[k]);
        end
        #10;
        src_valid = 1'b0;
        src_data  = '0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) begin
            @(negedge clk);
            check_bit("snk_valid", snk_valid, 1'b0);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
design/snn_pkg.sv
design/neuron.sv
design/network.sv
design/network_source.sv
design/network_sink.sv
design/snn_processor.sv
test/snn_processor_props.sv
test/snn_processor_tb.sv
